// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

# build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== mips_alu.sv ====
// ALU and shifter with zero flag for branch compare
`default_nettype none

module mips_alu import mips_pkg::*; (
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	input  shamt_t  shamt,
	output word_t   result,
	output logic    zero
);

	logic slt_bit;

	// signed compare for slt and slti
	assign slt_bit = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_NOR: result = ~(a | b);
			ALU_SLT: result = {{(DATA_WIDTH-1){1'b0}}, slt_bit};
			// shifts act on b, which carries rt
			ALU_SLL: result = b << shamt;
			ALU_SRL: result = b >> shamt;
			ALU_SRA: result = word_t'($signed(b) >>> shamt);
			ALU_PASS_UPPER: result = {b[15:0], 16'h0000};
			default: result = a + b;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== mips_core.sv ====
// single-cycle core top, decoder, register file, ALU and pc unit on memory ports
`default_nettype none

module mips_core import mips_pkg::*; #(
	parameter word_t reset_pc = '0
) (
	input  logic  clk,
	input  logic  arst_n,
	// instruction memory
	output word_t pc,
	input  word_t instr,
	// data memory
	output logic  memwrite,
	output word_t memaddr,
	output word_t writedata,
	input  word_t readdata
);

	word_t   rs_data, rt_data;
	word_t   alu_b;
	word_t   alu_result;
	word_t   wr_data;
	shamt_t  alu_shamt;
	rfaddr_t wr_addr;
	logic    alu_zero;

	mips_ctrl_if ctrl ();

	mips_decoder u_decoder (
		.instr (instr),
		.ctrl  (ctrl)
	);

	mips_regfile u_regfile (
		.clk     (clk),
		.arst_n  (arst_n),
		.rs_addr (ctrl.rs),
		.rt_addr (ctrl.rt),
		.wr_addr (wr_addr),
		.wr_en   (ctrl.reg_write),
		.wr_data (wr_data),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	// operand b and shift amount
	assign alu_b     = ctrl.alu_src_imm ? ctrl.imm : rt_data;
	assign alu_shamt = ctrl.shift_var ? rs_data[4:0] : ctrl.shamt;

	mips_alu u_alu (
		.op     (ctrl.alu_op),
		.a      (rs_data),
		.b      (alu_b),
		.shamt  (alu_shamt),
		.result (alu_result),
		.zero   (alu_zero)
	);

	mips_pc_unit #(
		.reset_pc (reset_pc)
	) u_pc_unit (
		.clk      (clk),
		.arst_n   (arst_n),
		.ctrl     (ctrl),
		.rs_data  (rs_data),
		.alu_zero (alu_zero),
		.pc       (pc)
	);

	// write-back path
	assign wr_addr = ctrl.dest_rt ? ctrl.rt : ctrl.rd;
	assign wr_data = ctrl.mem_to_reg ? readdata : alu_result;

	assign memaddr   = alu_result;
	assign writedata = rt_data;
	// no stores while held in reset
	assign memwrite  = ctrl.mem_write && arst_n;

endmodule

`default_nettype wire

// ==== mips_ctrl_if.sv ====
// decoded fields and control from the decoder to the datapath and the pc unit
`default_nettype none

interface mips_ctrl_if
	import mips_pkg::*;
();

	rfaddr_t   rs, rt, rd;
	shamt_t    shamt;
	word_t     imm;
	jaddress_t jidx;
	alu_op_t   alu_op;
	logic      alu_src_imm;
	logic      shift_var;
	logic      reg_write;
	logic      dest_rt;
	logic      mem_to_reg;
	logic      mem_write;
	logic      branch_eq, branch_ne;
	logic      jump, jump_reg;

	modport decoder (
		output rs, rt, rd, shamt, imm, jidx, alu_op, alu_src_imm, shift_var,
		output reg_write, dest_rt, mem_to_reg, mem_write,
		output branch_eq, branch_ne, jump, jump_reg
	);

	modport datapath (
		input rs, rt, rd, shamt, imm, alu_op, alu_src_imm, shift_var,
		input reg_write, dest_rt, mem_to_reg, mem_write
	);

	modport pc (
		input imm, jidx, branch_eq, branch_ne, jump, jump_reg
	);

endinterface

`default_nettype wire

// ==== mips_decoder.sv ====
// instruction field split, control decode and immediate extension
`default_nettype none

module mips_decoder import mips_pkg::*; (
	input  word_t        instr,
	mips_ctrl_if.decoder ctrl
);

	opcode_t    opcode;
	funct_t     funct;
	immediate_t imm16;
	logic       sign_ext;

	assign opcode = opcode_t'(instr[31:26]);
	assign funct  = funct_t'(instr[5:0]);
	assign imm16  = instr[15:0];

	// fields pass straight out, control decides which ones matter
	assign ctrl.rs    = instr[25:21];
	assign ctrl.rt    = instr[20:16];
	assign ctrl.rd    = instr[15:11];
	assign ctrl.shamt = instr[10:6];
	assign ctrl.jidx  = instr[25:0];

	assign ctrl.imm = sign_ext ? {{(DATA_WIDTH-16){imm16[15]}}, imm16}
	                           : {{(DATA_WIDTH-16){1'b0}}, imm16};

	always_comb begin
		// defaults give a no-op for anything unknown
		ctrl.alu_op      = ALU_ADD;
		ctrl.alu_src_imm = 1'b0;
		ctrl.shift_var   = 1'b0;
		ctrl.reg_write   = 1'b0;
		ctrl.dest_rt     = 1'b0;
		ctrl.mem_to_reg  = 1'b0;
		ctrl.mem_write   = 1'b0;
		ctrl.branch_eq   = 1'b0;
		ctrl.branch_ne   = 1'b0;
		ctrl.jump        = 1'b0;
		ctrl.jump_reg    = 1'b0;
		sign_ext         = 1'b0;

		case (opcode)
			RType: begin
				ctrl.reg_write = 1'b1;
				case (funct)
					ADD:  ctrl.alu_op = ALU_ADD;
					SUB:  ctrl.alu_op = ALU_SUB;
					AND:  ctrl.alu_op = ALU_AND;
					OR:   ctrl.alu_op = ALU_OR;
					XOR:  ctrl.alu_op = ALU_XOR;
					NOR:  ctrl.alu_op = ALU_NOR;
					SLT:  ctrl.alu_op = ALU_SLT;
					SLL:  ctrl.alu_op = ALU_SLL;
					SRL:  ctrl.alu_op = ALU_SRL;
					SRA:  ctrl.alu_op = ALU_SRA;
					SLLV: begin
						ctrl.alu_op    = ALU_SLL;
						ctrl.shift_var = 1'b1;
					end
					SRLV: begin
						ctrl.alu_op    = ALU_SRL;
						ctrl.shift_var = 1'b1;
					end
					SRAV: begin
						ctrl.alu_op    = ALU_SRA;
						ctrl.shift_var = 1'b1;
					end
					JR: begin
						ctrl.reg_write = 1'b0;
						ctrl.jump_reg  = 1'b1;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			ADDI, SLTI, ANDI, ORI, XORI, LUI: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write   = 1'b1;
				ctrl.dest_rt     = 1'b1;
				sign_ext         = (opcode == ADDI) || (opcode == SLTI);
				case (opcode)
					SLTI:    ctrl.alu_op = ALU_SLT;
					ANDI:    ctrl.alu_op = ALU_AND;
					ORI:     ctrl.alu_op = ALU_OR;
					XORI:    ctrl.alu_op = ALU_XOR;
					LUI:     ctrl.alu_op = ALU_PASS_UPPER;
					default: ctrl.alu_op = ALU_ADD;
				endcase
			end
			LW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write   = 1'b1;
				ctrl.dest_rt     = 1'b1;
				ctrl.mem_to_reg  = 1'b1;
				sign_ext         = 1'b1;
			end
			SW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write   = 1'b1;
				sign_ext         = 1'b1;
			end
			// compare by subtraction, alu zero flag decides
			BEQ, BNE: begin
				ctrl.alu_op    = ALU_SUB;
				ctrl.branch_eq = (opcode == BEQ);
				ctrl.branch_ne = (opcode == BNE);
				sign_ext       = 1'b1;
			end
			J: ctrl.jump = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== mips_pc_unit.sv ====
// program counter register with branch, jump and register-jump selection
`default_nettype none

module mips_pc_unit import mips_pkg::*; #(
	parameter word_t reset_pc = '0
) (
	input  logic    clk,
	input  logic    arst_n,
	mips_ctrl_if.pc ctrl,
	input  word_t   rs_data,
	input  logic    alu_zero,
	output word_t   pc
);

	word_t   pc_plus4;
	word_t   branch_target;
	word_t   jump_target;
	word_t   next_pc;
	logic    take_branch;
	pc_src_t pc_src;

	assign pc_plus4      = pc + word_t'(4);
	assign branch_target = pc_plus4 + (ctrl.imm << 2);
	// region bits come from pc + 4
	assign jump_target   = {pc_plus4[ADDR_WIDTH-1 -: 4], ctrl.jidx, 2'b00};

	assign take_branch = (ctrl.branch_eq && alu_zero) || (ctrl.branch_ne && !alu_zero);

	always_comb begin
		if (ctrl.jump_reg)
			pc_src = PC_REG;
		else if (ctrl.jump)
			pc_src = PC_JUMP;
		else if (take_branch)
			pc_src = PC_BRANCH;
		else
			pc_src = PC_SEQ;
	end

	always_comb begin
		case (pc_src)
			PC_BRANCH: next_pc = branch_target;
			PC_JUMP:   next_pc = jump_target;
			PC_REG:    next_pc = rs_data;
			default:   next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pc <= reset_pc;
		else
			pc <= next_pc;
	end

endmodule

`default_nettype wire

// ==== mips_pkg.sv ====
// word and field widths, field types, opcode and funct encodings, ALU and next-pc selects
`default_nettype none

package mips_pkg;

	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;
	localparam int REG_COUNT  = 32;

	typedef logic [DATA_WIDTH-1:0]        word_t;
	typedef logic [$clog2(REG_COUNT)-1:0] rfaddr_t;
	typedef logic [4:0]                   shamt_t;
	typedef logic [15:0]                  immediate_t;
	typedef logic [25:0]                  jaddress_t;

	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		RType = 6'h00,
		J     = 6'h02,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDI  = 6'h08,
		SLTI  = 6'h0A,
		ANDI  = 6'h0C,
		ORI   = 6'h0D,
		XORI  = 6'h0E,
		LUI   = 6'h0F,
		LW    = 6'h23,
		SW    = 6'h2B
	} opcode_t;

	// function field of R-type words, instr[5:0]
	typedef enum logic [5:0] {
		SLL  = 6'h00,
		SRL  = 6'h02,
		SRA  = 6'h03,
		SLLV = 6'h04,
		SRLV = 6'h06,
		SRAV = 6'h07,
		JR   = 6'h08,
		ADD  = 6'h20,
		SUB  = 6'h22,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		NOR  = 6'h27,
		SLT  = 6'h2A
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		// lui: low half of b moves to the upper half
		ALU_PASS_UPPER
	} alu_op_t;

	typedef enum logic [1:0] {
		PC_SEQ,
		PC_BRANCH,
		PC_JUMP,
		PC_REG
	} pc_src_t;

endpackage

`default_nettype wire

// ==== mips_regfile.sv ====
// general register file, two combinational reads, one clocked write, zero register
`default_nettype none

module mips_regfile import mips_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  rfaddr_t rs_addr,
	input  rfaddr_t rt_addr,
	input  rfaddr_t wr_addr,
	input  logic    wr_en,
	input  word_t   wr_data,
	output word_t   rs_data,
	output word_t   rt_data
);

	word_t regs [REG_COUNT];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// $0 is never written and keeps its reset value
	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

// ==== tb.f ====
mips_pkg.sv
mips_ctrl_if.sv
mips_decoder.sv
mips_regfile.sv
mips_alu.sv
mips_pc_unit.sv
mips_core.sv
tb_mips_mem.sv
tb_mips_core.sv

// ==== tb_mips_core.sv ====
// testbench top with clock, reset, program table, xorshift operands, run loop and checks
`default_nettype none

module tb_mips_core import mips_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam word_t RESET_PC   = 32'h0000_0040;
	localparam int    MAX_CYCLES = 200;

	localparam rfaddr_t R0 = 5'd0;
	localparam rfaddr_t RA = 5'd1;
	localparam rfaddr_t RB = 5'd2;
	// variable shift amount
	localparam rfaddr_t RS = 5'd3;
	localparam rfaddr_t RD = 5'd4;
	localparam rfaddr_t RI = 5'd5;
	localparam rfaddr_t RL = 5'd6;
	localparam rfaddr_t RC = 5'd7;
	localparam rfaddr_t RJ = 5'd8;

	logic  clk = 1'b0;
	logic  arst_n = 1'b1;
	word_t pc, instr, memaddr, writedata, readdata;
	logic  memwrite;

	// program table, one row per executed instruction
	word_t instr_q[$];
	word_t pc_q[$];
	bit    st_en_q[$];
	word_t st_addr_q[$];
	word_t st_data_q[$];
	int    test_q[$];

	word_t build_pc;
	word_t store_addr;
	word_t rng;
	int    cur_test;
	int    test_errs[6];
	string test_names[6];
	int    tests_failed;

	mips_core #(.reset_pc(RESET_PC)) uut (
		.clk       (clk),
		.arst_n    (arst_n),
		.pc        (pc),
		.instr     (instr),
		.memwrite  (memwrite),
		.memaddr   (memaddr),
		.writedata (writedata),
		.readdata  (readdata)
	);

	tb_mips_mem mem (
		.clk       (clk),
		.pc        (pc),
		.instr     (instr),
		.memwrite  (memwrite),
		.memaddr   (memaddr),
		.writedata (writedata),
		.readdata  (readdata)
	);

	initial begin
		forever #20 clk = ~clk;
	end

	function automatic word_t rtype_word(rfaddr_t rs, rfaddr_t rt, rfaddr_t rd, shamt_t sh,
		funct_t f);
		return {RType, rs, rt, rd, sh, f};
	endfunction

	function automatic word_t itype_word(opcode_t op, rfaddr_t rs, rfaddr_t rt, immediate_t imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jtype_word(opcode_t op, jaddress_t idx);
		return {op, idx};
	endfunction

	function automatic word_t xorshift32(word_t s);
		word_t x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word_t next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic word_t sext16(immediate_t x);
		return {{16{x[15]}}, x};
	endfunction

	function automatic word_t zext16(immediate_t x);
		return {16'h0000, x};
	endfunction

	// signed less-than from the sign bits, magnitude only when signs agree
	function automatic word_t slt_ref(word_t x, word_t y);
		if (x[31] != y[31])
			return {31'b0, x[31]};
		return {31'b0, x < y};
	endfunction

	function automatic word_t sra_ref(word_t v, shamt_t sh);
		word_t fill;
		fill = v[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0000_0000;
		return (v >> sh) | fill;
	endfunction

	function automatic word_t branch_target(word_t p, immediate_t imm);
		word_t off;
		off = sext16(imm);
		return p + 32'd4 + {off[29:0], 2'b00};
	endfunction

	function automatic word_t jump_target(word_t p, jaddress_t idx);
		word_t p4;
		p4 = p + 32'd4;
		return {p4[31:28], idx, 2'b00};
	endfunction

	task automatic add_row(word_t w, bit st_en, word_t sa, word_t sd, word_t next_pc);
		instr_q.push_back(w);
		pc_q.push_back(build_pc);
		st_en_q.push_back(st_en);
		st_addr_q.push_back(sa);
		st_data_q.push_back(sd);
		test_q.push_back(cur_test);
		build_pc = next_pc;
	endtask

	task automatic add_instr(word_t w);
		add_row(w, 1'b0, 32'h0, 32'h0, build_pc + 32'd4);
	endtask

	task automatic add_store(rfaddr_t r, word_t value);
		add_row(itype_word(SW, R0, r, store_addr[15:0]), 1'b1, store_addr, value,
			build_pc + 32'd4);
		store_addr = store_addr + 32'd4;
	endtask

	task automatic load_const(rfaddr_t r, word_t value);
		add_instr(itype_word(LUI, R0, r, value[31:16]));
		add_instr(itype_word(ORI, r, r, value[15:0]));
	endtask

	task automatic op_and_store(word_t w, rfaddr_t r, word_t expected);
		add_instr(w);
		add_store(r, expected);
	endtask

	task automatic build_program();
		word_t      a, b, c, v, lw_addr, jr_dest;
		shamt_t     sh;
		immediate_t imm_p, imm_n;

		build_pc   = RESET_PC;
		store_addr = 32'h0000_0100;

		// a store sits at reset_pc and must stay gated while in reset
		cur_test = 1;
		add_row(itype_word(SW, R0, R0, 16'h00F0), 1'b0, 32'h0, 32'h0, build_pc + 32'd4);
		// the first edge cleared that word
		add_instr(itype_word(LW, R0, RL, 16'h00F0));
		add_store(RL, 32'h0000_0000);

		// a non-negative, b negative, so signed and unsigned compares differ
		cur_test = 2;
		a  = next_rand() & 32'h7FFF_FFFF;
		b  = next_rand() | 32'h8000_0000;
		// even nonzero variable amount against an odd fixed amount
		c  = (next_rand() & 32'hFFFF_FFFE) | 32'h0000_0002;
		v  = next_rand();
		sh = v[4:0] | 5'd1;
		load_const(RA, a);
		load_const(RB, b);
		load_const(RS, c);
		op_and_store(rtype_word(RA, RB, RD, 5'd0, ADD), RD, a + b);
		op_and_store(rtype_word(RA, RB, RD, 5'd0, SUB), RD, a - b);
		op_and_store(rtype_word(RA, RB, RD, 5'd0, AND), RD, a & b);
		op_and_store(rtype_word(RA, RB, RD, 5'd0, OR), RD, a | b);
		op_and_store(rtype_word(RA, RB, RD, 5'd0, XOR), RD, a ^ b);
		op_and_store(rtype_word(RA, RB, RD, 5'd0, NOR), RD, ~(a | b));
		op_and_store(rtype_word(RA, RB, RD, 5'd0, SLT), RD, slt_ref(a, b));
		op_and_store(rtype_word(RB, RA, RD, 5'd0, SLT), RD, slt_ref(b, a));
		op_and_store(rtype_word(R0, RB, RD, sh, SLL), RD, b << sh);
		op_and_store(rtype_word(R0, RB, RD, sh, SRL), RD, b >> sh);
		op_and_store(rtype_word(R0, RB, RD, sh, SRA), RD, sra_ref(b, sh));
		op_and_store(rtype_word(RS, RB, RD, 5'd0, SLLV), RD, b << c[4:0]);
		op_and_store(rtype_word(RS, RB, RD, 5'd0, SRLV), RD, b >> c[4:0]);
		op_and_store(rtype_word(RS, RB, RD, 5'd0, SRAV), RD, sra_ref(b, c[4:0]));

		cur_test = 3;
		v     = next_rand();
		imm_p = v[31:16] & 16'h7FFF;
		imm_n = v[15:0] | 16'h8000;
		op_and_store(itype_word(ADDI, RA, RI, imm_n), RI, a + sext16(imm_n));
		op_and_store(itype_word(SLTI, RA, RI, imm_n), RI, slt_ref(a, sext16(imm_n)));
		op_and_store(itype_word(SLTI, RB, RI, imm_p), RI, slt_ref(b, sext16(imm_p)));
		op_and_store(itype_word(ANDI, RA, RI, imm_n), RI, a & zext16(imm_n));
		op_and_store(itype_word(ORI, RA, RI, imm_n), RI, a | zext16(imm_n));
		op_and_store(itype_word(XORI, RA, RI, imm_n), RI, a ^ zext16(imm_n));
		op_and_store(itype_word(LUI, R0, RI, imm_n), RI, {imm_n, 16'h0000});
		op_and_store(itype_word(ADDI, RA, R0, imm_p), R0, 32'h0000_0000);

		cur_test = 4;
		lw_addr = store_addr;
		add_store(RB, b);
		add_instr(itype_word(LW, R0, RL, lw_addr[15:0]));
		add_store(RL, b);

		// RC copies a, so RA equals RC and differs from RB
		cur_test = 5;
		jr_dest = 32'h0000_0380;
		add_instr(rtype_word(RA, R0, RC, 5'd0, OR));
		add_row(itype_word(BEQ, RA, RC, 16'h0002), 1'b0, 32'h0, 32'h0,
			branch_target(build_pc, 16'h0002));
		add_instr(itype_word(BEQ, RA, RB, 16'h0002));
		add_row(itype_word(BNE, RA, RB, 16'h0003), 1'b0, 32'h0, 32'h0,
			branch_target(build_pc, 16'h0003));
		add_instr(itype_word(BNE, RA, RC, 16'h0003));
		add_row(jtype_word(J, 26'h00000C0), 1'b0, 32'h0, 32'h0,
			jump_target(build_pc, 26'h00000C0));
		// backward branch by 64 words
		add_row(itype_word(BEQ, R0, R0, 16'hFFC0), 1'b0, 32'h0, 32'h0,
			branch_target(build_pc, 16'hFFC0));
		load_const(RJ, jr_dest);
		add_row(rtype_word(RJ, R0, R0, 5'd0, JR), 1'b0, 32'h0, 32'h0, jr_dest);
		add_store(RJ, jr_dest);
	endtask

	task automatic finish_test(int t);
		if (test_errs[t] == 0) begin
			$display("test %0d %s: ok", t, test_names[t]);
		end else begin
			$display("test %0d %s: failed with %0d errors", t, test_names[t], test_errs[t]);
			tests_failed++;
		end
	endtask

	task automatic check_row(int r);
		int t;

		t = test_q[r];
		if (pc !== pc_q[r]) begin
			$display("ERR %0t: row %0d pc %h, expected %h", $time, r, pc, pc_q[r]);
			test_errs[t]++;
		end
		if (memwrite !== 1'b0 && !st_en_q[r]) begin
			$display("ERR %0t: row %0d unexpected store to %h", $time, r, memaddr);
			test_errs[t]++;
		end else if (st_en_q[r]) begin
			if (memwrite !== 1'b1) begin
				$display("ERR %0t: row %0d memwrite low, store expected", $time, r);
				test_errs[t]++;
			end
			if (memaddr !== st_addr_q[r]) begin
				$display("ERR %0t: row %0d memaddr %h, expected %h", $time, r, memaddr,
					st_addr_q[r]);
				test_errs[t]++;
			end
			if (writedata !== st_data_q[r]) begin
				$display("ERR %0t: row %0d writedata %h, expected %h", $time, r, writedata,
					st_data_q[r]);
				test_errs[t]++;
			end
		end
		if (r == pc_q.size() - 1 || test_q[r + 1] != t)
			finish_test(t);
	endtask

	initial begin
		int row;
		int cycles;
		int total;
		bit timed_out;

		$timeformat(-9, 0, " ns", 0);
		rng          = 32'h5989;
		tests_failed = 0;
		for (int i = 0; i < 6; i++) begin
			test_errs[i] = 0;
		end
		test_names[1] = "reset and first step";
		test_names[2] = "register ALU and shifts";
		test_names[3] = "immediates and register 0";
		test_names[4] = "load after store";
		test_names[5] = "branches and jumps";

		build_program();
		for (int i = 0; i < 256; i++) begin
			mem.rom[i] = 32'h0000_0000;
		end
		foreach (pc_q[i]) begin
			mem.rom[pc_q[i][9:2]] = instr_q[i];
		end

		@(negedge clk);
		arst_n = 1'b0;
		for (int c = 0; c < 5; c++) begin
			@(negedge clk);
			if (pc !== RESET_PC) begin
				$display("ERR %0t: pc %h during reset, expected %h", $time, pc, RESET_PC);
				test_errs[1]++;
			end
			if (memwrite !== 1'b0) begin
				$display("ERR %0t: memwrite not low during reset", $time);
				test_errs[1]++;
			end
		end

		// pc still holds reset_pc here, which is row 0
		check_row(0);
		arst_n = 1'b1;
		row    = 1;
		cycles = 0;
		while (row < pc_q.size() && cycles < MAX_CYCLES) begin
			@(negedge clk);
			cycles++;
			check_row(row);
			row++;
		end

		timed_out = (row < pc_q.size());
		if (timed_out)
			$display("run loop stopped after %0d cycles with %0d rows left", cycles,
				pc_q.size() - row);
		total = timed_out ? 1 : 0;
		for (int i = 1; i < 6; i++) begin
			total += test_errs[i];
		end
		$display("5 tests, %0d failed, %0d errors", tests_failed, total);
		if (total == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_mips_mem.sv ====
// instruction ROM and data RAM models on the core's memory ports
`default_nettype none

module tb_mips_mem import mips_pkg::*; (
	input  logic  clk,
	input  word_t pc,
	output word_t instr,
	input  logic  memwrite,
	input  word_t memaddr,
	input  word_t writedata,
	output word_t readdata
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ROM_WORDS = 256;
	localparam int RAM_WORDS = 256;

	// rom is filled by the testbench top before reset
	word_t rom [ROM_WORDS];
	word_t ram [RAM_WORDS];

	// word addressed, low two bits ignored
	assign instr    = rom[pc[9:2]];
	assign readdata = ram[memaddr[9:2]];

	// each word starts distinct, tied to its byte address
	initial begin
		for (int i = 0; i < RAM_WORDS; i++) begin
			ram[i] <= 32'hC0DE_0000 | word_t'(i * 4);
		end
	end

	always @(posedge clk) begin
		if (memwrite) begin
			ram[memaddr[9:2]] <= writedata;
		end
	end

endmodule

`default_nettype wire
